//--- rv_pkg.sv
`default_nettype none

package rv_pkg;

  // vector types
  typedef logic [31:0] word_t;      // data, register value, address
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [3:0]  wmask_t;     // one bit per byte lane

  // major opcodes of the executed subset
  localparam opcode_t op_imm    = 7'b001_0011;
  localparam opcode_t op_lui    = 7'b011_0111;
  localparam opcode_t op_auipc  = 7'b001_0111;
  localparam opcode_t op_jal    = 7'b110_1111;
  localparam opcode_t op_jalr   = 7'b110_0111;
  localparam opcode_t op_load   = 7'b000_0011;
  localparam opcode_t op_store  = 7'b010_0011;
  localparam opcode_t op_system = 7'b111_0011;   // only ebreak expected here

  localparam word_t reset_pc = 32'h8000_0000;

  // load/store size codes from funct3
  localparam funct3_t f3_byte   = 3'b000;
  localparam funct3_t f3_half   = 3'b001;
  localparam funct3_t f3_word   = 3'b010;
  localparam funct3_t f3_byte_u = 3'b100;
  localparam funct3_t f3_half_u = 3'b101;

  // next pc source
  typedef enum logic [1:0] {
    pc_seq  = 2'd0,   // pc + 4
    pc_jump = 2'd1,   // adder result
    pc_hold = 2'd2    // halted
  } next_pc_sel_e;

  // register writeback source
  typedef enum logic [1:0] {
    wb_sum  = 2'd0,
    wb_link = 2'd1,   // return address
    wb_load = 2'd2
  } wb_sel_e;

endpackage

`default_nettype wire

//--- rv_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface rv_ctrl_if;
  import rv_pkg::*;

  word_t        rs1_data;
  word_t        rs2_data;
  word_t        imm;           // selected immediate
  logic         use_pc_base;   // adder base is pc, else rs1
  next_pc_sel_e next_pc_sel;
  wb_sel_e      wb_sel;
  logic         reg_wen;
  logic         mem_read;
  logic         mem_write;
  funct3_t      funct3;

  modport dec (
    output imm, use_pc_base, next_pc_sel, wb_sel,
    output reg_wen, mem_read, mem_write, funct3
  );

  modport exe (input rs1_data, imm, use_pc_base, next_pc_sel, wb_sel);

  modport lsu (input funct3, rs2_data, mem_read, mem_write);

endinterface

`default_nettype wire

//--- rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
  input  rv_pkg::inst_t     inst,
  rv_ctrl_if.dec            ctl,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::reg_addr_t rd_addr,
  output logic              halt
);
  import rv_pkg::*;

  opcode_t opcode;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_u;
  word_t   imm_j;

  assign opcode = inst[6:0];

  // lui reads x0 so the adder sees a zero base
  assign rs1_addr = (opcode == op_lui) ? reg_addr_t'(0) : inst[19:15];
  assign rs2_addr = inst[24:20];
  assign rd_addr  = inst[11:7];

  assign ctl.funct3 = inst[14:12];

  // sign-extended immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  assign halt = (opcode == op_system);

  always_comb begin
    // unknown opcodes fall through as a no-op
    ctl.imm         = imm_i;
    ctl.use_pc_base = 1'b0;
    ctl.next_pc_sel = pc_seq;
    ctl.wb_sel      = wb_sum;
    ctl.reg_wen     = 1'b0;
    ctl.mem_read    = 1'b0;
    ctl.mem_write   = 1'b0;

    case (opcode)
      op_imm: begin
        ctl.reg_wen = 1'b1;   // every funct3 runs as addi
      end
      op_lui: begin
        ctl.imm     = imm_u;
        ctl.reg_wen = 1'b1;
      end
      op_auipc: begin
        ctl.imm         = imm_u;
        ctl.use_pc_base = 1'b1;
        ctl.reg_wen     = 1'b1;
      end
      op_jal: begin
        ctl.imm         = imm_j;
        ctl.use_pc_base = 1'b1;
        ctl.next_pc_sel = pc_jump;
        ctl.wb_sel      = wb_link;
        ctl.reg_wen     = 1'b1;
      end
      op_jalr: begin
        ctl.next_pc_sel = pc_jump;
        ctl.wb_sel      = wb_link;
        ctl.reg_wen     = 1'b1;
      end
      op_load: begin
        ctl.wb_sel   = wb_load;
        ctl.reg_wen  = 1'b1;
        ctl.mem_read = 1'b1;
      end
      op_store: begin
        ctl.imm       = imm_s;
        ctl.mem_write = 1'b1;
      end
      op_system: begin
        ctl.next_pc_sel = pc_hold;   // ebreak parks the core
      end
      default: ;
    endcase
  end

  // a single memory access per instruction
  assert final (!(ctl.mem_read && ctl.mem_write))
    else $error("decode drives mem_read and mem_write together");

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wen,
  input  rv_pkg::reg_addr_t waddr,
  input  rv_pkg::word_t     wdata,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);
  import rv_pkg::*;

  word_t regs [1:31];   // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst_n && wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // x0 reads zero on both ports, whatever was written to it
  assert property (@(posedge clk)
    (rs1_addr != '0 || rs1_data == '0) && (rs2_addr != '0 || rs2_data == '0))
    else $error("x0 read returned nonzero");

endmodule

`default_nettype wire

//--- rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
  input  logic          clk,
  input  logic          rst_n,
  rv_ctrl_if.exe        ctl,
  input  rv_pkg::word_t load_data,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t addr_sum,
  output rv_pkg::word_t wb_data
);
  import rv_pkg::*;

  word_t base;
  word_t pc_plus4;
  word_t next_pc;

  assign pc_plus4 = pc + 32'd4;

  // shared adder for addi, lui, auipc, jumps and memory addresses
  assign base     = ctl.use_pc_base ? pc : ctl.rs1_data;
  assign addr_sum = base + ctl.imm;

  always_comb begin
    case (ctl.next_pc_sel)
      pc_jump: next_pc = {addr_sum[31:1], 1'b0};   // jalr drops bit 0
      pc_hold: next_pc = pc;
      default: next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  always_comb begin
    case (ctl.wb_sel)
      wb_link: wb_data = pc_plus4;
      wb_load: wb_data = load_data;
      default: wb_data = addr_sum;
    endcase
  end

  // jump targets in the program keep the pc on word boundaries
  assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("pc misaligned: %h", pc);

endmodule

`default_nettype wire

//--- rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_lsu (
  rv_ctrl_if.lsu         ctl,
  input  logic [1:0]     addr_low,
  input  rv_pkg::word_t  mem_rdata,
  output rv_pkg::word_t  mem_wdata,
  output rv_pkg::wmask_t mem_wmask,
  output rv_pkg::word_t  load_data
);
  import rv_pkg::*;

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // lane picked from the aligned word
  assign ld_byte = mem_rdata[8*addr_low +: 8];
  assign ld_half = addr_low[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    case (ctl.funct3)
      f3_byte:   load_data = {{24{ld_byte[7]}}, ld_byte};
      f3_half:   load_data = {{16{ld_half[15]}}, ld_half};
      f3_byte_u: load_data = {24'h0, ld_byte};
      f3_half_u: load_data = {16'h0, ld_half};
      default:   load_data = mem_rdata;   // lw
    endcase
    if (!ctl.mem_read) begin
      load_data = '0;
    end
  end

  always_comb begin
    case (ctl.funct3)
      f3_byte: begin
        mem_wdata = {4{ctl.rs2_data[7:0]}};
        mem_wmask = 4'b0001 << addr_low;
      end
      f3_half: begin
        mem_wdata = {2{ctl.rs2_data[15:0]}};
        mem_wmask = addr_low[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        mem_wdata = ctl.rs2_data;   // sw and odd codes store a word
        mem_wmask = 4'b1111;
      end
    endcase
    if (!ctl.mem_write) begin
      mem_wmask = '0;
    end
  end

  // a decoded store always touches at least one byte
  assert final (!ctl.mem_write || mem_wmask != '0)
    else $error("store with empty byte mask");

endmodule

`default_nettype wire

//--- rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input  logic           clk,
  input  logic           rst_n,
  input  rv_pkg::inst_t  inst,
  output rv_pkg::word_t  pc,
  output rv_pkg::word_t  mem_addr,
  input  rv_pkg::word_t  mem_rdata,
  output rv_pkg::word_t  mem_wdata,
  output rv_pkg::wmask_t mem_wmask,
  output logic           mem_read,
  output logic           mem_write,
  output logic           halt
);
  import rv_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     load_data;
  word_t     wb_data;
  logic      dec_halt;

  rv_ctrl_if ctl ();

  assign ctl.rs1_data = rs1_data;
  assign ctl.rs2_data = rs2_data;

  rv_decode rv_decode_inst (
    .inst     (inst),
    .ctl      (ctl.dec),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .halt     (dec_halt)
  );

  rv_regfile rv_regfile_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wen      (ctl.reg_wen),
    .waddr    (rd_addr),
    .wdata    (wb_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute rv_execute_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctl       (ctl.exe),
    .load_data (load_data),
    .pc        (pc),
    .addr_sum  (mem_addr),
    .wb_data   (wb_data)
  );

  rv_lsu rv_lsu_inst (
    .ctl       (ctl.lsu),
    .addr_low  (mem_addr[1:0]),
    .mem_rdata (mem_rdata),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .load_data (load_data)
  );

  // memory levels and halt stay quiet in reset
  assign mem_read  = rst_n & ctl.mem_read;
  assign mem_write = rst_n & ctl.mem_write;
  assign halt      = rst_n & dec_halt;

endmodule

`default_nettype wire

//--- tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
  import rv_pkg::*;

  localparam int rom_words  = 64;
  localparam int timeout_ns = (rom_words + 20) * 40;   // whole rom plus margin
  localparam inst_t ebreak  = 32'h0010_0073;

  logic   clk;
  logic   rst_n;
  inst_t  inst;
  word_t  pc, mem_addr, mem_rdata, mem_wdata;
  wmask_t mem_wmask;
  logic   mem_read, mem_write, halt;

  // program rom and the expected behavior of each slot
  inst_t  rom       [rom_words];
  word_t  exp_next  [rom_words];
  logic   exp_wr    [rom_words];
  logic   exp_rd    [rom_words];
  logic   exp_halt  [rom_words];
  word_t  exp_addr  [rom_words];
  word_t  exp_wdata [rom_words];
  wmask_t exp_mask  [rom_words];
  word_t  dmem      [64];
  word_t  shadow    [64];   // untouched copy for load expectations
  int     n;
  int     ld_word;
  int     errors;
  word_t  seed;
  word_t  cur_word;
  logic [5:0] cur;
  word_t  prev_next;
  logic   prev_valid;

  rv_core rv_core_inst (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  assign cur_word  = (pc - reset_pc) >> 2;
  assign cur       = cur_word[5:0];
  assign inst      = rom[cur];
  assign mem_rdata = dmem[mem_addr[7:2]];

  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (mem_write && mem_wmask[b]) dmem[mem_addr[7:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
    end
    prev_next  <= exp_next[cur];
    prev_valid <= rst_n;
  end

  function automatic word_t xorshift(input word_t s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic inst_t itype(input int imm, input int rs1, input funct3_t f3,
                                  input int rd, input opcode_t op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic inst_t stype(input int imm, input int rs2, input int rs1,
                                  input funct3_t f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], op_store};
  endfunction

  function automatic inst_t jtype(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
  endfunction

  // load result per the extraction rule
  function automatic word_t extract(input word_t w, input funct3_t f3, input int off);
    logic [7:0]  b;
    logic [15:0] h;
    b = w >> (8 * off);
    h = w >> (8 * off);
    case (f3)
      f3_byte:   return {{24{b[7]}}, b};
      f3_half:   return {{16{h[15]}}, h};
      f3_byte_u: return {24'h0, b};
      f3_half_u: return {16'h0, h};
      default:   return w;
    endcase
  endfunction

  function automatic word_t lanes(input wmask_t m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  task automatic put(input inst_t i);
    rom[n]      = i;
    exp_next[n] = reset_pc + 4 * (n + 1);
    exp_halt[n] = 1'b0;
    n++;
  endtask

  task automatic expect_store(input word_t a, input word_t d, input wmask_t m);
    exp_wr[n-1]    = 1'b1;
    exp_addr[n-1]  = a;
    exp_wdata[n-1] = d;
    exp_mask[n-1]  = m;
  endtask

  // load one word lane, then store the result for checking
  task automatic load_and_store(input funct3_t f3, input int off);
    put(itype(4 * ld_word + off, 0, f3, 10, op_load));
    exp_rd[n-1] = 1'b1;
    put(stype(216, 10, 0, f3_word));
    expect_store(32'd216, extract(shadow[ld_word], f3, off), 4'hf);
    ld_word++;
  endtask

  // x4 lands in the addressed lanes, low byte first
  task automatic store_lane(input funct3_t f3, input int off, input wmask_t m);
    put(stype(-67 + off, 4, 2, f3));   // x2 + imm lands on 0xe0
    expect_store(32'h0000_00e0 + off, 32'h9234_500c << (8 * off), m);
  endtask

  assert property (@(posedge clk) !rst_n |-> !mem_read && !mem_write && !halt)
    else begin
      errors++;
      $display("memory level or halt high during reset");
    end

  assert property (@(posedge clk) $rose(rst_n) |-> pc == reset_pc)
    else begin
      errors++;
      $display("FAIL pc expected %h got %h", reset_pc, pc);
    end

  assert property (@(posedge clk) disable iff (!rst_n) prev_valid |-> pc == prev_next)
    else begin
      errors++;
      $display("FAIL pc expected %h got %h", prev_next, pc);
    end

  assert property (@(posedge clk) disable iff (!rst_n) mem_write == exp_wr[cur])
    else begin
      errors++;
      $display("FAIL mem_write expected %h got %h", exp_wr[cur], mem_write);
    end

  assert property (@(posedge clk) disable iff (!rst_n) mem_read == exp_rd[cur])
    else begin
      errors++;
      $display("FAIL mem_read expected %h got %h", exp_rd[cur], mem_read);
    end

  assert property (@(posedge clk) disable iff (!rst_n) halt == exp_halt[cur])
    else begin
      errors++;
      $display("FAIL halt expected %h got %h", exp_halt[cur], halt);
    end

  assert property (@(posedge clk) disable iff (!rst_n) exp_wr[cur] |-> mem_addr == exp_addr[cur])
    else begin
      errors++;
      $display("FAIL mem_addr expected %h got %h", exp_addr[cur], mem_addr);
    end

  assert property (@(posedge clk) disable iff (!rst_n) exp_wr[cur] |-> mem_wmask == exp_mask[cur])
    else begin
      errors++;
      $display("FAIL mem_wmask expected %h got %h", exp_mask[cur], mem_wmask);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    exp_wr[cur] |-> (mem_wdata & lanes(exp_mask[cur])) == (exp_wdata[cur] & lanes(exp_mask[cur])))
    else begin
      errors++;
      $display("FAIL mem_wdata expected %h got %h", exp_wdata[cur] & lanes(exp_mask[cur]),
               mem_wdata & lanes(exp_mask[cur]));
    end

  initial begin
    rst_n   = 1'b0;
    errors  = 0;
    n       = 0;
    ld_word = 0;
    seed    = 32'h3038;
    prev_valid = 1'b0;
    for (int i = 0; i < 64; i++) begin
      seed      = xorshift(seed);
      dmem[i]   = seed;
      shadow[i] = seed;
      rom[i]      = ebreak;   // anything past the program parks the core
      exp_next[i] = reset_pc + 4 * i;
      exp_wr[i]   = 1'b0;
      exp_rd[i]   = 1'b0;
      exp_halt[i] = 1'b1;
    end
    put(stype(220, 0, 0, f3_word));          // presented while reset holds the pc
    expect_store(32'd220, 32'h0000_0000, 4'hf);
    put(itype(12'h123, 0, 3'b000, 2, op_imm));
    put({20'habcde, 5'd3, op_lui});
    put({20'h12345, 5'd4, op_auipc});        // pc 0x8000_000c
    put(itype(-5, 2, 3'b000, 5, op_imm));
    put(stype(192, 2, 0, f3_word));
    expect_store(32'd192, 32'h0000_0123, 4'hf);
    put(stype(196, 3, 0, f3_word));
    expect_store(32'd196, 32'habcd_e000, 4'hf);
    put(stype(200, 4, 0, f3_word));
    expect_store(32'd200, 32'h9234_500c, 4'hf);
    put(stype(204, 5, 0, f3_word));
    expect_store(32'd204, 32'h0000_011e, 4'hf);
    put(jtype(8, 6));
    exp_next[n-1] = reset_pc + 32'h2c;
    put(itype(1, 0, 3'b000, 7, op_imm));     // jumped over
    put(stype(208, 6, 0, f3_word));
    expect_store(32'd208, reset_pc + 32'h28, 4'hf);
    put({20'h00000, 5'd8, op_auipc});
    put(itype(13, 8, 3'b000, 9, op_jalr));   // odd target, bit 0 dropped
    exp_next[n-1] = reset_pc + 32'h3c;
    put(itype(1, 0, 3'b000, 7, op_imm));     // jumped over
    put(stype(212, 9, 0, f3_word));
    expect_store(32'd212, reset_pc + 32'h38, 4'hf);
    for (int off = 0; off < 4; off++) load_and_store(f3_byte, off);
    for (int off = 0; off < 4; off++) load_and_store(f3_byte_u, off);
    for (int off = 0; off < 4; off += 2) load_and_store(f3_half, off);
    for (int off = 0; off < 4; off += 2) load_and_store(f3_half_u, off);
    load_and_store(f3_word, 0);
    for (int off = 0; off < 4; off++) store_lane(f3_byte, off, 4'b0001 << off);
    store_lane(f3_half, 0, 4'b0011);
    store_lane(f3_half, 2, 4'b1100);
    store_lane(f3_word, 0, 4'b1111);

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    while (!halt) @(posedge clk);
    repeat (3) @(posedge clk);   // pc must hold across these edges
    rst_n <= 1'b0;               // reset over ebreak, then over the first store
    repeat (2) @(posedge clk);
    $display("%0d errors", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("timeout, the core never reached ebreak");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
rv_pkg.sv
rv_ctrl_if.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_lsu.sv
rv_core.sv
tb_rv_core.sv
